// File: dbg_ring_consts.svh
`ifndef DBG_RING_CONSTS_SVH
`define DBG_RING_CONSTS_SVH

`default_nettype none

// ring geometry
`define DBG_NUM_TILES 4   // debug nodes on the ring, one per tile

// per-node register file
`define DBG_REG_COUNT 8   // registers in each node
`define DBG_ADDR_W    3   // register index width

// flit fields
`define DBG_DATA_W    16  // register and payload width
`define DBG_ID_W      4   // node id, 0 is the host, tiles 1..4

`default_nettype wire

`endif

// File: dbg_ring_pkg.sv
`include "dbg_ring_consts.svh"
`default_nettype none

package dbg_ring_pkg;

   // commands come from the host, responses go back to it
   typedef enum logic [1:0] {
      REG_READ  = 2'd0,  // host asks for a register
      REG_WRITE = 2'd1,  // host sets a register
      READ_RESP = 2'd2,  // node returns register value
      WRITE_ACK = 2'd3   // node confirms write, data echoed
   } dbg_op_e;

   // one flit carries a whole packet
   typedef struct packed {
      dbg_op_e                 op;    // what to do
      logic [`DBG_ID_W-1:0]    dest;  // target node id
      logic [`DBG_ID_W-1:0]    src;   // sender id
      logic [`DBG_ADDR_W-1:0]  addr;  // register index
      logic [`DBG_DATA_W-1:0]  data;  // write data or read result
   } dbg_flit_t;

endpackage

`default_nettype wire

// File: dbg_host_tx.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module dbg_host_tx (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    cmd_valid_i,  // host has a command
   output logic                    cmd_ready_o,  // injector can take it
   input  logic                    cmd_write_i,  // 1 write, 0 read
   input  logic [`DBG_ID_W-1:0]    cmd_dest_i,   // target tile id
   input  logic [`DBG_ADDR_W-1:0]  cmd_addr_i,   // register index
   input  logic [`DBG_DATA_W-1:0]  cmd_data_i,   // write data
   output logic                    out_valid_o,  // flit toward node 0
   input  logic                    out_ready_i,
   output dbg_ring_pkg::dbg_flit_t out_flit_o
);
   import dbg_ring_pkg::*;

   logic      out_valid_q;  // output register holds a flit
   dbg_flit_t out_flit_q;   // flit waiting for the ring
   dbg_flit_t cmd_flit;     // host command in flit form
   logic      cmd_accept;   // command taken this cycle

   // free slot, or the slot drains this cycle
   assign cmd_ready_o = !out_valid_q || out_ready_i;
   assign cmd_accept  = cmd_valid_i && cmd_ready_o;

   always_comb begin
      cmd_flit      = '0;
      cmd_flit.op   = cmd_write_i ? REG_WRITE : REG_READ;
      cmd_flit.dest = cmd_dest_i;
      cmd_flit.src  = '0;            // host is id 0
      cmd_flit.addr = cmd_addr_i;
      cmd_flit.data = cmd_data_i;    // ignored by reads
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
      end else if (cmd_ready_o) begin
         out_valid_q <= cmd_valid_i;  // refill or go empty
      end
   end

   // payload only moves on a transfer
   always_ff @(posedge clk_i) begin
      if (cmd_accept) begin
         out_flit_q <= cmd_flit;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_flit_o  = out_flit_q;

endmodule

`default_nettype wire

// File: dbg_ring_node.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module dbg_ring_node #(
   parameter int NODE_ID = 1  // ring id of this tile, never 0
) (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    in_valid_i,   // flit from upstream hop
   output logic                    in_ready_o,
   input  dbg_ring_pkg::dbg_flit_t in_flit_i,
   output logic                    out_valid_o,  // flit to downstream hop
   input  logic                    out_ready_i,
   output dbg_ring_pkg::dbg_flit_t out_flit_o,
   output logic [`DBG_DATA_W-1:0]  ctrl_o        // register 0 to the tile
);
   import dbg_ring_pkg::*;

   localparam logic [`DBG_ID_W-1:0] MY_ID = NODE_ID[`DBG_ID_W-1:0];

   logic [`DBG_DATA_W-1:0] regs_q [`DBG_REG_COUNT];  // node register file
   logic      out_valid_q;  // output stage occupied
   dbg_flit_t out_flit_q;   // output stage payload
   logic      in_accept;    // upstream transfer this cycle
   logic      is_cmd;       // flit still a host command
   logic      hit;          // command meant for this node
   dbg_flit_t rsp_flit;     // answer built from the command
   dbg_flit_t next_flit;    // what goes into the output stage

   assign in_ready_o = !out_valid_q || out_ready_i;  // one slot, pass-through when draining
   assign in_accept  = in_valid_i && in_ready_o;

   assign is_cmd = (in_flit_i.op == REG_READ) || (in_flit_i.op == REG_WRITE);
   assign hit    = is_cmd && (in_flit_i.dest == MY_ID);

   // response reuses the command's slot on the ring
   always_comb begin
      rsp_flit      = in_flit_i;
      rsp_flit.dest = '0;     // back to host
      rsp_flit.src  = MY_ID;
      if (in_flit_i.op == REG_WRITE) begin
         rsp_flit.op = WRITE_ACK;  // data field echoes the write
      end else begin
         rsp_flit.op   = READ_RESP;
         rsp_flit.data = regs_q[in_flit_i.addr];
      end
   end

   assign next_flit = hit ? rsp_flit : in_flit_i;  // consume or forward

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `DBG_REG_COUNT; i++) begin
            regs_q[i] <= '0;
         end
      end else if (in_accept && hit && (in_flit_i.op == REG_WRITE)) begin
         regs_q[in_flit_i.addr] <= in_flit_i.data;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
      end else if (in_ready_o) begin
         out_valid_q <= in_valid_i;  // load next or empty out
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_accept) begin
         out_flit_q <= next_flit;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_flit_o  = out_flit_q;
   assign ctrl_o      = regs_q[0];  // drives the tile's control

endmodule

`default_nettype wire

// File: dbg_host_rx.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module dbg_host_rx (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    in_valid_i,   // flit from last node
   output logic                    in_ready_o,
   input  dbg_ring_pkg::dbg_flit_t in_flit_i,
   output logic                    rsp_valid_o,  // response for the host
   input  logic                    rsp_ready_i,
   output logic [`DBG_ID_W-1:0]    rsp_src_o,    // answering tile, 0 if unclaimed
   output dbg_ring_pkg::dbg_op_e   rsp_op_o,
   output logic [`DBG_ADDR_W-1:0]  rsp_addr_o,
   output logic [`DBG_DATA_W-1:0]  rsp_data_o,
   output logic                    rsp_err_o     // command went round unconsumed
);
   import dbg_ring_pkg::*;

   logic      rsp_valid_q;  // response stage occupied
   dbg_flit_t rsp_flit_q;   // flit as it left the ring
   logic      in_accept;
   logic      unclaimed;    // stored flit is still a command

   assign in_ready_o = !rsp_valid_q || rsp_ready_i;  // host back-pressure starts here
   assign in_accept  = in_valid_i && in_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_valid_q <= 1'b0;
      end else if (in_ready_o) begin
         rsp_valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_accept) begin
         rsp_flit_q <= in_flit_i;  // kept verbatim, errors echo it
      end
   end

   // no node answered, op is still read or write
   assign unclaimed = (rsp_flit_q.op == REG_READ) || (rsp_flit_q.op == REG_WRITE);

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_src_o   = rsp_flit_q.src;
   assign rsp_op_o    = rsp_flit_q.op;
   assign rsp_addr_o  = rsp_flit_q.addr;
   assign rsp_data_o  = rsp_flit_q.data;
   assign rsp_err_o   = rsp_valid_q && unclaimed;  // only flagged with a live response

endmodule

`default_nettype wire

// File: dbg_ring_system.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module dbg_ring_system (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  cmd_valid_i,
   output logic                                  cmd_ready_o,
   input  logic                                  cmd_write_i,
   input  logic [`DBG_ID_W-1:0]                  cmd_dest_i,
   input  logic [`DBG_ADDR_W-1:0]                cmd_addr_i,
   input  logic [`DBG_DATA_W-1:0]                cmd_data_i,
   output logic                                  rsp_valid_o,
   input  logic                                  rsp_ready_i,
   output logic [`DBG_ID_W-1:0]                  rsp_src_o,
   output dbg_ring_pkg::dbg_op_e                 rsp_op_o,
   output logic [`DBG_ADDR_W-1:0]                rsp_addr_o,
   output logic [`DBG_DATA_W-1:0]                rsp_data_o,
   output logic                                  rsp_err_o,
   output logic [`DBG_NUM_TILES*`DBG_DATA_W-1:0] tile_ctrl_o  // one slice per tile
);
   import dbg_ring_pkg::*;

   // hop k feeds node k, the last hop feeds the collector
   logic      [`DBG_NUM_TILES:0] hop_valid;
   logic      [`DBG_NUM_TILES:0] hop_ready;
   dbg_flit_t [`DBG_NUM_TILES:0] hop_flit;

   dbg_host_tx i_dbg_host_tx (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_write_i (cmd_write_i),
      .cmd_dest_i  (cmd_dest_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_data_i  (cmd_data_i),
      .out_valid_o (hop_valid[0]),
      .out_ready_i (hop_ready[0]),
      .out_flit_o  (hop_flit[0])
   );

   for (genvar i = 0; i < `DBG_NUM_TILES; i++) begin : gen_node
      dbg_ring_node #(
         .NODE_ID (i + 1)  // id 0 stays with the host
      ) i_dbg_ring_node (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .in_valid_i  (hop_valid[i]),
         .in_ready_o  (hop_ready[i]),
         .in_flit_i   (hop_flit[i]),
         .out_valid_o (hop_valid[i+1]),
         .out_ready_i (hop_ready[i+1]),
         .out_flit_o  (hop_flit[i+1]),
         .ctrl_o      (tile_ctrl_o[i*`DBG_DATA_W +: `DBG_DATA_W])
      );
   end

   dbg_host_rx i_dbg_host_rx (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (hop_valid[`DBG_NUM_TILES]),
      .in_ready_o  (hop_ready[`DBG_NUM_TILES]),
      .in_flit_i   (hop_flit[`DBG_NUM_TILES]),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_src_o   (rsp_src_o),
      .rsp_op_o    (rsp_op_o),
      .rsp_addr_o  (rsp_addr_o),
      .rsp_data_o  (rsp_data_o),
      .rsp_err_o   (rsp_err_o)
   );

endmodule

`default_nettype wire

// File: dbg_ring_checker.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module dbg_ring_checker (
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,
   input  logic [`DBG_NUM_TILES:0]                 hop_valid_i,
   input  logic [`DBG_NUM_TILES:0]                 hop_ready_i,
   input  dbg_ring_pkg::dbg_flit_t [`DBG_NUM_TILES:0] hop_flit_i,
   input  logic                                    rsp_valid_i,
   input  logic                                    rsp_ready_i,
   input  logic [`DBG_ID_W-1:0]                    rsp_src_i,
   input  dbg_ring_pkg::dbg_op_e                   rsp_op_i,
   input  logic [`DBG_ADDR_W-1:0]                  rsp_addr_i,
   input  logic [`DBG_DATA_W-1:0]                  rsp_data_i,
   input  logic                                    rsp_err_i
);
   import dbg_ring_pkg::*;

   // a stalled hop keeps its flit until the receiver takes it
   for (genvar k = 0; k <= `DBG_NUM_TILES; k++) begin : gen_hop
      hop_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         hop_valid_i[k] && !hop_ready_i[k] |=> hop_valid_i[k] && $stable(hop_flit_i[k]))
         else $error("hop %0d dropped or changed its flit while stalled", k);
   end

   rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_i && !rsp_ready_i |=>
         rsp_valid_i && $stable({rsp_src_i, rsp_op_i, rsp_addr_i, rsp_data_i, rsp_err_i}))
      else $error("host response changed while stalled");

   // unclaimed command still carries the host src
   err_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_err_i |-> rsp_valid_i && (rsp_src_i == '0))
      else $error("rsp_err_o high without rsp_valid_o or with a tile src");

   quiet_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |-> (hop_valid_i == '0) && !rsp_valid_i)
      else $error("valid seen while reset is asserted");

endmodule

bind dbg_ring_system dbg_ring_checker i_dbg_ring_checker (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .hop_valid_i (hop_valid),
   .hop_ready_i (hop_ready),
   .hop_flit_i  (hop_flit),
   .rsp_valid_i (rsp_valid_o),
   .rsp_ready_i (rsp_ready_i),
   .rsp_src_i   (rsp_src_o),
   .rsp_op_i    (rsp_op_o),
   .rsp_addr_i  (rsp_addr_o),
   .rsp_data_i  (rsp_data_o),
   .rsp_err_i   (rsp_err_o)
);

`default_nettype wire

// File: tb_dbg_ring_system.sv
`timescale 1ns/1ps
`include "dbg_ring_consts.svh"
`default_nettype none

module tb_dbg_ring_system;
   import dbg_ring_pkg::*;

   localparam int NT       = `DBG_NUM_TILES;
   localparam int NR       = `DBG_REG_COUNT;
   localparam int NUM_CMDS = 176;  // 32 + 64 + 8 + 12 + 60
   localparam int CMD_NS   = 200;  // budget per command

   typedef struct packed {
      logic [`DBG_ID_W-1:0]   src;
      dbg_op_e                op;
      logic [`DBG_ADDR_W-1:0] addr;
      logic [`DBG_DATA_W-1:0] data;
      logic                   err;
   } exp_rsp_t;

   logic                         clk_i, rst_n_i;
   logic                         cmd_valid_i, cmd_ready_o, cmd_write_i;
   logic [`DBG_ID_W-1:0]         cmd_dest_i;
   logic [`DBG_ADDR_W-1:0]       cmd_addr_i;
   logic [`DBG_DATA_W-1:0]       cmd_data_i;
   logic                         rsp_valid_o, rsp_ready_i, rsp_err_o;
   logic [`DBG_ID_W-1:0]         rsp_src_o;
   dbg_op_e                      rsp_op_o;
   logic [`DBG_ADDR_W-1:0]       rsp_addr_o;
   logic [`DBG_DATA_W-1:0]       rsp_data_o;
   logic [NT*`DBG_DATA_W-1:0]    tile_ctrl_o;

   logic [`DBG_DATA_W-1:0] model_regs [NT][NR];  // mirror of every node register
   exp_rsp_t exp_q [$];                           // responses still owed, in order
   int       seed = 32'h4244_b989;
   logic     bp_on;            // random stalls on rsp_ready_i
   logic     verdict_printed;

   dbg_ring_system i_dbg_ring_system (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_write_i (cmd_write_i),
      .cmd_dest_i  (cmd_dest_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_data_i  (cmd_data_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_src_o   (rsp_src_o),
      .rsp_op_o    (rsp_op_o),
      .rsp_addr_o  (rsp_addr_o),
      .rsp_data_o  (rsp_data_o),
      .rsp_err_o   (rsp_err_o),
      .tile_ctrl_o (tile_ctrl_o)
   );

   always #10 clk_i = ~clk_i;  // 20 ns period

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
         verdict_printed = 1'b1;
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic logic [NT*`DBG_DATA_W-1:0] model_ctrl();
      logic [NT*`DBG_DATA_W-1:0] v;
      for (int t = 0; t < NT; t++) begin
         v[t*`DBG_DATA_W +: `DBG_DATA_W] = model_regs[t][0];  // reg 0 drives the slice
      end
      return v;
   endfunction

   // queue the expected answer, then hand the command over
   task automatic send_cmd(input logic wr, input logic [`DBG_ID_W-1:0] dest,
                           input logic [`DBG_ADDR_W-1:0] addr, input logic [`DBG_DATA_W-1:0] data);
      exp_rsp_t exp;
      logic     taken;
      exp.addr = addr;
      exp.data = data;
      if (dest >= 4'd1 && dest <= 4'(NT)) begin
         exp.src = dest;
         exp.err = 1'b0;
         if (wr) begin
            exp.op = WRITE_ACK;
            model_regs[int'(dest) - 1][addr] = data;
         end else begin
            exp.op   = READ_RESP;
            exp.data = model_regs[int'(dest) - 1][addr];
         end
      end else begin
         exp.src = '0;             // nobody claims it, comes back as sent
         exp.op  = wr ? REG_WRITE : REG_READ;
         exp.err = 1'b1;
      end
      exp_q.push_back(exp);
      cmd_valid_i = 1'b1;
      cmd_write_i = wr;
      cmd_dest_i  = dest;
      cmd_addr_i  = addr;
      cmd_data_i  = data;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk_i);
         taken = cmd_ready_o;  // transfer on the coming edge
         @(posedge clk_i);
      end
      #1;
      cmd_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic watch_responses();
      exp_rsp_t exp;
      forever begin
         @(negedge clk_i);
         if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
               verdict_printed = 1'b1;
               $display("a response arrived with no command outstanding");
               $display("Done: errors found");
               $fatal(1, "extra response");
            end else begin
               exp = exp_q.pop_front();
               check_value(64'(rsp_src_o), 64'(exp.src), "rsp_src_o");
               check_value(64'(rsp_op_o), 64'(exp.op), "rsp_op_o");
               check_value(64'(rsp_addr_o), 64'(exp.addr), "rsp_addr_o");
               check_value(64'(rsp_data_o), 64'(exp.data), "rsp_data_o");
               check_value(64'(rsp_err_o), 64'(exp.err), "rsp_err_o");
            end
         end
      end
   endtask

   task automatic toggle_rsp_ready();
      int r;
      forever begin
         @(posedge clk_i);
         #1;
         r = $random(seed);
         rsp_ready_i = bp_on ? r[0] : 1'b1;
      end
   endtask

   task automatic run_watchdog();
      #(NUM_CMDS * CMD_NS + 2000);
      verdict_printed = 1'b1;
      $display("timeout: responses still missing at %0t", $time);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   endtask

   task automatic test_reset_state();
      check_value(64'(tile_ctrl_o), 64'(0), "tile_ctrl_o after reset");
      for (int t = 1; t <= NT; t++) begin
         for (int a = 0; a < NR; a++) begin
            send_cmd(1'b0, 4'(t), 3'(a), 16'hffff);  // zero must come from the register
         end
      end
      wait_idle();
   endtask

   task automatic test_write_read();
      for (int t = 1; t <= NT; t++) begin
         for (int a = 0; a < NR; a++) begin
            send_cmd(1'b1, 4'(t), 3'(a), 16'(t * 4096 + a * 257 + 165));
            send_cmd(1'b0, 4'(t), 3'(a), 16'h0);
         end
      end
      wait_idle();
   endtask

   task automatic test_ctrl_outputs();
      for (int t = 1; t <= NT; t++) begin
         send_cmd(1'b1, 4'(t), 3'd0, 16'(32'hc000 + t));
         wait_idle();
         check_value(64'(tile_ctrl_o), 64'(model_ctrl()), "tile_ctrl_o after reg 0 write");
         send_cmd(1'b1, 4'(t), 3'd5, 16'(t * 3855));  // other register, slice must hold
         wait_idle();
         check_value(64'(tile_ctrl_o), 64'(model_ctrl()), "tile_ctrl_o after reg 5 write");
      end
   endtask

   task automatic test_unclaimed();
      send_cmd(1'b1, 4'd0, 3'd2, 16'hdead);
      send_cmd(1'b0, 4'd0, 3'd6, 16'h1234);
      send_cmd(1'b1, 4'd7, 3'd6, 16'hbeef);
      send_cmd(1'b0, 4'd7, 3'd2, 16'h4321);
      for (int t = 1; t <= NT; t++) begin
         send_cmd(1'b0, 4'(t), 3'd2, 16'h0);  // registers must be untouched
         send_cmd(1'b0, 4'(t), 3'd6, 16'h0);
      end
      wait_idle();
      check_value(64'(tile_ctrl_o), 64'(model_ctrl()), "tile_ctrl_o after unclaimed");
   endtask

   task automatic test_backpressure();
      int r;
      bp_on = 1'b1;
      repeat (60) begin
         r = $random(seed);
         send_cmd(r[0], 4'(r[2:1]) + 4'd1, r[5:3], r[31:16]);
      end
      wait_idle();
      bp_on = 1'b0;
   endtask

   initial begin
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_write_i = 1'b0;
      cmd_dest_i = '0;
      cmd_addr_i = '0;
      cmd_data_i = '0;
      rsp_ready_i = 1'b1;
      bp_on = 1'b0;
      verdict_printed = 1'b0;
      for (int t = 0; t < NT; t++) begin
         for (int a = 0; a < NR; a++) begin
            model_regs[t][a] = '0;
         end
      end
      fork
         run_watchdog();
         watch_responses();
         toggle_rsp_ready();
      join_none
      repeat (5) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      test_reset_state();
      test_write_read();
      test_ctrl_outputs();
      test_unclaimed();
      test_backpressure();
      repeat (10) @(posedge clk_i);  // a stray extra response would show up here
      verdict_printed = 1'b1;
      $display("Done: no errors");
      $finish;
   end

   // an assertion can end the run without a verdict line
   final begin
      if (!verdict_printed) begin
         $display("simulation stopped before the tests completed");
         $display("Done: errors found");
      end
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
dbg_ring_pkg.sv
dbg_host_tx.sv
dbg_ring_node.sv
dbg_host_rx.sv
dbg_ring_system.sv
dbg_ring_checker.sv
tb_dbg_ring_system.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_dbg_ring_system -f flist.f
out=$(./obj_dir/Vtb_dbg_ring_system 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Done: no errors"
